// File: source/display_pkg.sv
// shared widths, timing constants and types for the four-digit seven-segment driver
// modules pull these in with a wildcard import in their headers
`default_nettype none

package display_pkg;

	// display geometry
	localparam int NUM_DIGITS      = 4; // digits on the display
	localparam int SEGMENTS        = 7; // segments a..g per digit
	localparam int SLOTS_PER_DIGIT = 8; // seven segment slots then one blank slot
	localparam int BCD_WIDTH       = 4; // bits per bcd digit

	// scan timing, kept small for simulation
	localparam int SLOT_CYCLES      = 4; // clocks per slot
	localparam int FRAME_CYCLES     = NUM_DIGITS * SLOTS_PER_DIGIT * SLOT_CYCLES; // 128
	localparam int FRAMES_PER_COUNT = 2; // full frames between count advances

	// counter widths
	localparam int PRESCALE_WIDTH = $clog2(SLOT_CYCLES); // slot prescaler bits
	localparam int TALLY_WIDTH    = $clog2(FRAMES_PER_COUNT + 1); // frame tally bits

	typedef logic [BCD_WIDTH-1:0] bcd_digit_t; // one decimal digit, 0 to 9

	// four digits packed, most significant digit in the upper nibble
	typedef logic [NUM_DIGITS*BCD_WIDTH-1:0] display_count_t;

	// active low, bit 6 is segment a down to bit 0 for segment g
	typedef logic [SEGMENTS-1:0] segment_pattern_t;

	typedef logic [NUM_DIGITS-1:0] anode_select_t; // one-hot, bit 0 is the rightmost digit

	typedef logic [$clog2(SLOTS_PER_DIGIT)-1:0] slot_index_t; // slot within a digit

	typedef logic [PRESCALE_WIDTH-1:0] prescale_t; // clock count inside a slot

	typedef logic [TALLY_WIDTH-1:0] frame_tally_t; // frames seen since last advance

	// what the counter does on the next edge
	typedef enum logic [1:0] {
		update_hold    = 2'd0, // keep the count
		update_advance = 2'd1, // add one with decimal carry
		update_clear   = 2'd2  // back to 0000
	} count_update_t;

endpackage

`default_nettype wire

// File: source/digit_counter.sv
// four-digit bcd counter that steps once every FRAMES_PER_COUNT display frames
// run gates the frame tally, clear returns the count to zero and wins over advance
`timescale 1ns/100ps
`default_nettype none

module digit_counter
	import display_pkg::*;
(
	input  logic           CLK,
	input  logic           reset,     // sync, active high
	input  logic           run,       // level, counting allowed
	input  logic           clear,     // one-cycle pulse
	input  logic           frame_end, // last clock of each frame
	output display_count_t count
);

	frame_tally_t   tally;     // frames counted toward the next advance
	count_update_t  update;    // choice for this edge
	display_count_t count_inc; // count plus one in decimal
	bcd_digit_t     digit;     // working digit for the carry chain
	logic           carry;     // ripple carry between digits
	logic           tally_full; // this frame completes the tally

	assign tally_full = (tally == TALLY_WIDTH'(FRAMES_PER_COUNT - 1));

	always_comb begin
		if (clear) begin
			update = update_clear; // clear beats everything
		end else if (frame_end && run && tally_full) begin
			update = update_advance;
		end else begin
			update = update_hold;
		end
	end

	// decimal increment, a 9 rolls to 0 and carries into the next digit
	always_comb begin
		carry = 1'b1; // adding one
		for (int i = 0; i < NUM_DIGITS; i++) begin
			digit = count[i*BCD_WIDTH +: BCD_WIDTH];
			if (carry) begin
				if (digit >= bcd_digit_t'(9)) begin
					digit = '0; // roll over, keep carrying
				end else begin
					digit = digit + 1'b1;
					carry = 1'b0; // carry absorbed
				end
			end
			count_inc[i*BCD_WIDTH +: BCD_WIDTH] = digit;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			count <= '0;
			tally <= '0;
		end else begin
			case (update)
				update_clear: begin
					count <= '0;
					tally <= '0; // clear restarts the tally
				end
				update_advance: begin
					count <= count_inc; // 9999 wraps to 0000
					tally <= '0;
				end
				default: begin
					if (frame_end && run) begin
						tally <= tally + 1'b1; // frames with run low are ignored
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/pattern_latch.sv
// decodes the bcd count into active-low segment patterns
// all four patterns reload together on frame_end so a frame never mixes two counts
`timescale 1ns/100ps
`default_nettype none

module pattern_latch
	import display_pkg::*;
(
	input  logic             CLK,
	input  logic             reset,     // sync, active high
	input  logic             frame_end, // snapshot strobe
	input  display_count_t   count,     // live count from the counter
	output segment_pattern_t pattern_0, // least significant digit
	output segment_pattern_t pattern_1,
	output segment_pattern_t pattern_2,
	output segment_pattern_t pattern_3  // most significant digit
);

	segment_pattern_t decoded [NUM_DIGITS]; // per-digit decode of the live count

	// active-low table, segment a in bit 6 through g in bit 0
	function automatic segment_pattern_t decode_digit(input bcd_digit_t value);
		segment_pattern_t seg;
		case (value)
			4'h0:    seg = 7'b0000001;
			4'h1:    seg = 7'b1001111;
			4'h2:    seg = 7'b0010010;
			4'h3:    seg = 7'b0000110;
			4'h4:    seg = 7'b1001100;
			4'h5:    seg = 7'b0100100;
			4'h6:    seg = 7'b0100000;
			4'h7:    seg = 7'b0001111;
			4'h8:    seg = 7'b0000000;
			default: seg = 7'b0000100; // 9, and anything out of range
		endcase
		return seg;
	endfunction

	always_comb begin
		for (int i = 0; i < NUM_DIGITS; i++) begin
			decoded[i] = decode_digit(count[i*BCD_WIDTH +: BCD_WIDTH]);
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			pattern_0 <= decode_digit('0); // display starts at 0000
			pattern_1 <= decode_digit('0);
			pattern_2 <= decode_digit('0);
			pattern_3 <= decode_digit('0);
		end else if (frame_end) begin
			pattern_0 <= decoded[0]; // in force from the next frame's first cycle
			pattern_1 <= decoded[1];
			pattern_2 <= decoded[2];
			pattern_3 <= decoded[3];
		end
	end

endmodule

`default_nettype wire

// File: source/segment_scanner.sv
// walks the digits one segment slot at a time, lighting at most one segment
// each digit gets seven segment slots and one blank slot, each SLOT_CYCLES clocks long
`timescale 1ns/100ps
`default_nettype none

module segment_scanner
	import display_pkg::*;
(
	input  logic             CLK,
	input  logic             reset,     // sync, active high
	input  segment_pattern_t pattern_0, // digit 0, rightmost
	input  segment_pattern_t pattern_1,
	input  segment_pattern_t pattern_2,
	input  segment_pattern_t pattern_3, // digit 3, leftmost
	output logic             frame_end, // last clock of digit 3 slot 7
	output anode_select_t    anode,     // active high, one-hot
	output segment_pattern_t seg_n      // active low, at most one bit low
);

	prescale_t        prescale;      // clock within the current slot
	prescale_t        prescale_next;
	slot_index_t      slot;          // slot within the current digit
	slot_index_t      slot_next;
	anode_select_t    anode_next;
	segment_pattern_t pattern_sel;   // pattern of the digit about to be shown
	segment_pattern_t slot_mask;     // one-hot mask of the segment for the next slot
	segment_pattern_t seg_next;
	logic             slot_done;     // final clock of a slot
	logic             last_slot;     // blank slot of the digit

	assign slot_done = (prescale == prescale_t'(SLOT_CYCLES - 1));
	assign last_slot = (slot == slot_index_t'(SLOTS_PER_DIGIT - 1));

	// frame ends as digit 3 finishes its blank slot
	assign frame_end = anode[NUM_DIGITS-1] & last_slot & slot_done;

	// sequencer next state
	always_comb begin
		prescale_next = prescale;
		slot_next     = slot;
		anode_next    = anode;
		if (anode == '0) begin
			anode_next    = anode_select_t'(1); // first clock out of reset, digit 0 slot 0
			slot_next     = '0;
			prescale_next = '0;
		end else if (slot_done) begin
			prescale_next = '0;
			if (last_slot) begin
				slot_next  = '0;
				anode_next = {anode[NUM_DIGITS-2:0], anode[NUM_DIGITS-1]}; // rotate, 3 wraps to 0
			end else begin
				slot_next = slot + 1'b1;
			end
		end else begin
			prescale_next = prescale + 1'b1;
		end
	end

	// pattern for the digit that will be lit next cycle
	always_comb begin
		case (anode_next)
			4'b0001: pattern_sel = pattern_0;
			4'b0010: pattern_sel = pattern_1;
			4'b0100: pattern_sel = pattern_2;
			4'b1000: pattern_sel = pattern_3;
			default: pattern_sel = '1; // nothing lit
		endcase
	end

	// slot k drives only bit 6-k, the blank slot drives nothing
	always_comb begin
		slot_mask = '0;
		if (slot_next < slot_index_t'(SEGMENTS)) begin
			slot_mask[SEGMENTS-1-slot_next] = 1'b1;
		end
		seg_next = pattern_sel | ~slot_mask; // unmasked bits forced high
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			anode    <= '0; // dark until the first clock after reset
			slot     <= '0;
			prescale <= '0;
			seg_n    <= '1; // all segments off
		end else begin
			anode    <= anode_next;
			slot     <= slot_next;
			prescale <= prescale_next;
			seg_n    <= seg_next; // registered so no glitch lights two segments
		end
	end

endmodule

`default_nettype wire

// File: source/display_top.sv
// top of the multiplexed display driver, counter into latch into scanner
// run and clear come from outside, anode and seg_n go to the board
`timescale 1ns/100ps
`default_nettype none

module display_top
	import display_pkg::*;
(
	input  logic             CLK,
	input  logic             reset, // sync, active high
	input  logic             run,   // level, lets the count advance
	input  logic             clear, // one-cycle pulse, count to 0000
	output anode_select_t    anode, // digit drive, active high
	output segment_pattern_t seg_n  // segment drive, active low
);

	display_count_t   count;     // live bcd count
	logic             frame_end; // frame boundary strobe
	segment_pattern_t pattern_0; // latched patterns, digit 0 rightmost
	segment_pattern_t pattern_1;
	segment_pattern_t pattern_2;
	segment_pattern_t pattern_3;

	digit_counter digit_counter_inst (
		.CLK       (CLK),
		.reset     (reset),
		.run       (run),
		.clear     (clear),
		.frame_end (frame_end),
		.count     (count)
	);

	pattern_latch pattern_latch_inst (
		.CLK       (CLK),
		.reset     (reset),
		.frame_end (frame_end),
		.count     (count),
		.pattern_0 (pattern_0),
		.pattern_1 (pattern_1),
		.pattern_2 (pattern_2),
		.pattern_3 (pattern_3)
	);

	segment_scanner segment_scanner_inst (
		.CLK       (CLK),
		.reset     (reset),
		.pattern_0 (pattern_0),
		.pattern_1 (pattern_1),
		.pattern_2 (pattern_2),
		.pattern_3 (pattern_3),
		.frame_end (frame_end),
		.anode     (anode),
		.seg_n     (seg_n)
	);

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
// clock and reset source for the display testbench
// 10 ns clock, reset held high for the first eight rising edges
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic CLK,
	output logic reset // sync, active high
);

	localparam int HALF_PERIOD  = 5; // ns
	localparam int RESET_CYCLES = 8;

	initial begin
		CLK = 1'b0;
		forever #HALF_PERIOD CLK = ~CLK;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1 reset = 1'b0; // released just after the edge, like other stimulus
	end

endmodule

`default_nettype wire

// File: verif/display_checker.sv
// concurrent checks on the scanner outputs
// bound into segment_scanner from the testbench
`timescale 1ns/100ps
`default_nettype none

module display_checker
	import display_pkg::*;
(
	input logic             CLK,
	input logic             reset, // sync, active high
	input anode_select_t    anode, // digit drive from the scanner
	input segment_pattern_t seg_n  // segment drive, active low
);

	// never more than one segment lit
	one_segment_lit: assert property (
		@(posedge CLK) disable iff (reset) $onehot0(~seg_n)
	) else $error("more than one segment driven low, seg_n=%b", seg_n);

	// at most one digit selected
	anode_one_hot: assert property (
		@(posedge CLK) disable iff (reset) $onehot0(anode)
	) else $error("anode is not one-hot, anode=%b", anode);

	// no digit selected means all segments dark
	dark_without_anode: assert property (
		@(posedge CLK) disable iff (reset) (anode == '0) |-> (seg_n == '1)
	) else $error("segment lit with no anode, seg_n=%b", seg_n);

endmodule

`default_nettype wire

// File: verif/display_tb.sv
// table-driven testbench for the multiplexed display driver
// each row sets run and clear, skips frames, then decodes one scanned frame from the pins
// and compares every digit against the expected count
`timescale 1ns/100ps
`default_nettype none

module display_tb
	import display_pkg::*;
();

	localparam int NUM_STEPS     = 20;
	localparam int RESET_BUDGET  = 16;  // cycles for reset and first frame sync
	localparam int MARGIN_FRAMES = 3;

	typedef struct packed {
		logic           run;         // run level for this row
		logic           clear;       // pulse clear at the row start
		logic [7:0]     wait_frames; // frames skipped before the decoded one
		display_count_t expected;    // count shown in the decoded frame
	} step_t;

	logic             CLK;
	logic             reset;
	logic             run;
	logic             clear;
	anode_select_t    anode;
	segment_pattern_t seg_n;
	int               cycle_count = 0;
	int               cycle_limit = 0;

	// run, clear, wait, expected; every row starts on a frame boundary
	step_t steps [NUM_STEPS] = '{
		'{1'b0, 1'b0, 8'd0, 16'h0000}, // reset state, anode walk
		'{1'b1, 1'b0, 8'd1, 16'h0000}, // run starts, first advance still in flight
		'{1'b1, 1'b0, 8'd1, 16'h0001},
		'{1'b1, 1'b0, 8'd1, 16'h0002},
		'{1'b1, 1'b0, 8'd1, 16'h0003}, // every digit code shows once
		'{1'b1, 1'b0, 8'd1, 16'h0004},
		'{1'b1, 1'b0, 8'd1, 16'h0005},
		'{1'b1, 1'b0, 8'd1, 16'h0006},
		'{1'b1, 1'b0, 8'd1, 16'h0007},
		'{1'b1, 1'b0, 8'd1, 16'h0008},
		'{1'b1, 1'b0, 8'd1, 16'h0009},
		'{1'b1, 1'b0, 8'd1, 16'h0010}, // decimal carry
		'{1'b0, 1'b0, 8'd3, 16'h0011}, // last advance lands, then hold
		'{1'b0, 1'b0, 8'd3, 16'h0011},
		'{1'b1, 1'b0, 8'd3, 16'h0012},
		'{1'b1, 1'b0, 8'd0, 16'h0012}, // tally now one frame in
		'{1'b1, 1'b1, 8'd1, 16'h0000}, // clear mid run, zero next frame
		'{1'b1, 1'b0, 8'd0, 16'h0000}, // tally restarted, no early step
		'{1'b1, 1'b0, 8'd0, 16'h0001},
		'{1'b0, 1'b0, 8'd1, 16'h0002}
	};

	tb_clock_gen tb_clock_gen_inst (
		.CLK   (CLK),
		.reset (reset)
	);

	display_top display_top_inst (
		.CLK   (CLK),
		.reset (reset),
		.run   (run),
		.clear (clear),
		.anode (anode),
		.seg_n (seg_n)
	);

	bind segment_scanner display_checker display_checker_inst (
		.CLK   (CLK),
		.reset (reset),
		.anode (anode),
		.seg_n (seg_n)
	);

	// active-high lit segments a..g for each decimal digit, inverted for the pins
	function automatic segment_pattern_t expected_segments(input bcd_digit_t value);
		segment_pattern_t lit;
		case (value)
			4'd0:    lit = 7'b1111110; // abcdef
			4'd1:    lit = 7'b0110000; // bc
			4'd2:    lit = 7'b1101101; // abdeg
			4'd3:    lit = 7'b1111001; // abcdg
			4'd4:    lit = 7'b0110011; // bcfg
			4'd5:    lit = 7'b1011011; // acdfg
			4'd6:    lit = 7'b1011111; // acdefg
			4'd7:    lit = 7'b1110000; // abc
			4'd8:    lit = 7'b1111111;
			default: lit = 7'b1111011; // abcdfg
		endcase
		return ~lit;
	endfunction

	task automatic compare_pattern(input segment_pattern_t actual,
		input segment_pattern_t expected, input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s, got %b expected %b", $time, what, actual, expected);
			$display("*** FAILED ***");
			$fatal(1, "segment pattern mismatch");
		end
	endtask

	task automatic compare_anode(input anode_select_t actual,
		input anode_select_t expected, input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s, got %b expected %b", $time, what, actual, expected);
			$display("*** FAILED ***");
			$fatal(1, "anode mismatch");
		end
	endtask

	// one clock, then settle past the edge for driving and sampling
	task automatic step_cycle();
		@(posedge CLK);
		#1;
	endtask

	// frame starts where anode moves from the last digit back to digit 0
	task automatic wait_next_frame_start();
		anode_select_t prev;
		prev = anode;
		step_cycle();
		while (!(anode == anode_select_t'(1) &&
			prev == anode_select_t'(1 << (NUM_DIGITS - 1)))) begin
			prev = anode;
			step_cycle();
		end
	endtask

	task automatic pulse_clear();
		clear = 1'b1;
		step_cycle();
		clear = 1'b0;
	endtask

	// called on cycle 0 of a frame, returns on its last cycle
	task automatic check_frame(input display_count_t expected);
		segment_pattern_t rebuilt [NUM_DIGITS];
		segment_pattern_t bit_mask;
		anode_select_t    want_anode;
		int               digit;
		int               slot;
		for (int d = 0; d < NUM_DIGITS; d++) begin
			rebuilt[d] = '1;
		end
		for (int cyc = 0; cyc < FRAME_CYCLES; cyc++) begin
			if (cyc > 0) begin
				step_cycle();
			end
			digit      = cyc / (SLOTS_PER_DIGIT * SLOT_CYCLES);
			slot       = (cyc / SLOT_CYCLES) % SLOTS_PER_DIGIT;
			want_anode = anode_select_t'(1 << digit);
			compare_anode(anode, want_anode, $sformatf("anode, digit %0d slot %0d", digit, slot));
			if (cyc % SLOT_CYCLES == SLOT_CYCLES / 2) begin // mid slot, away from edges
				if (slot < SEGMENTS) begin
					bit_mask = segment_pattern_t'(1) << (SEGMENTS - 1 - slot);
					if ((seg_n & bit_mask) == '0) begin
						rebuilt[digit] = rebuilt[digit] & ~bit_mask;
					end
					compare_pattern(seg_n | bit_mask, '1,
						$sformatf("segment outside its slot, digit %0d slot %0d", digit, slot));
				end else begin
					compare_pattern(seg_n, '1, $sformatf("blank slot, digit %0d", digit));
				end
			end
		end
		for (int d = 0; d < NUM_DIGITS; d++) begin
			compare_pattern(rebuilt[d], expected_segments(expected[d*BCD_WIDTH +: BCD_WIDTH]),
				$sformatf("digit %0d of count %h", d, expected));
		end
	endtask

	// run limit from the table length
	always @(posedge CLK) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("timeout: the table did not finish within %0d clock cycles", cycle_limit);
			$display("*** FAILED ***");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	initial begin
		int total_frames;
		run          = 1'b0;
		clear        = 1'b0;
		total_frames = 0;
		for (int i = 0; i < NUM_STEPS; i++) begin
			total_frames = total_frames + int'(steps[i].wait_frames) + 1; // skipped plus decoded
		end
		cycle_limit = RESET_BUDGET + (total_frames + MARGIN_FRAMES) * FRAME_CYCLES;
		@(negedge reset);
		while (anode != anode_select_t'(1)) begin
			step_cycle(); // first clock out of reset starts frame 0
		end
		for (int i = 0; i < NUM_STEPS; i++) begin
			run = steps[i].run;
			if (steps[i].clear) begin
				pulse_clear();
			end
			repeat (int'(steps[i].wait_frames)) wait_next_frame_start();
			check_frame(steps[i].expected);
			wait_next_frame_start();
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
source/display_pkg.sv
source/digit_counter.sv
source/pattern_latch.sv
source/segment_scanner.sv
source/display_top.sv
verif/tb_clock_gen.sv
verif/display_checker.sv
verif/display_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the display testbench with Verilator and run it from the project root
# exit status is zero only when the testbench finishes without a fatal error

cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal \
		-f project.f --top-module display_tb -o display_sim \
	&& ./obj_dir/display_sim \
	|| exit 1
